/* list.f */
rtl/pkt_filter_pkg.sv
rtl/proto_classifier.sv
rtl/filter_policy.sv
rtl/filter_channel.sv
rtl/pkt_filter_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* rtl/filter_channel.sv */
/*
  One direction of the tap. Both outputs share a joined ready, so a stall
  on either sink blocks the input. Outputs are combinational from the
  input beat; packet state only moves on accepted beats.
*/
`timescale 1ns/1ps
`default_nettype none

module filter_channel
  import pkt_filter_pkg::*;
(
  input  logic              nclk,
  input  logic              nresetn_r,
  input  logic [CFG_W-1:0]  filter_config,
  // Input stream
  input  logic              in_tvalid,
  output logic              in_tready,
  input  logic [DATA_W-1:0] in_tdata,
  input  logic [KEEP_W-1:0] in_tkeep,
  input  logic              in_tlast,
  // Pass-through copy
  output logic              pass_tvalid,
  input  logic              pass_tready,
  output logic [DATA_W-1:0] pass_tdata,
  output logic [KEEP_W-1:0] pass_tkeep,
  output logic              pass_tlast,
  // Filtered stream
  output logic              filt_tvalid,
  input  logic              filt_tready,
  output logic [DATA_W-1:0] filt_tdata,
  output logic [KEEP_W-1:0] filt_tkeep,
  output logic              filt_tlast
);

  logic              accept;
  logic              in_pkt;
  logic              pkt_dropped;
  logic              hdr_remaining;
  logic              is_ipv4;
  logic              is_ipv6;
  logic              is_arp;
  logic              is_icmp4;
  logic              is_icmp6;
  logic              is_udp4;
  logic              is_udp6;
  logic              is_tcp4;
  logic              is_roce4;
  logic              roce_aeth;
  logic              roce_reth;
  logic              drop_beat;
  logic              cut_beat;
  logic [KEEP_W-1:0] cut_keep;
  logic              spill;

  // Ready join across both sinks
  assign in_tready = pass_tready && filt_tready;
  assign accept    = in_tvalid && in_tready;

  // Unmodified copy of every accepted beat
  assign pass_tvalid = accept;
  assign pass_tdata  = in_tdata;
  assign pass_tkeep  = in_tkeep;
  assign pass_tlast  = in_tlast;

  proto_classifier u_classifier (
    .beat      (in_tdata),
    .is_ipv4   (is_ipv4),
    .is_ipv6   (is_ipv6),
    .is_arp    (is_arp),
    .is_icmp4  (is_icmp4),
    .is_icmp6  (is_icmp6),
    .is_udp4   (is_udp4),
    .is_udp6   (is_udp6),
    .is_tcp4   (is_tcp4),
    .is_roce4  (is_roce4),
    .roce_aeth (roce_aeth),
    .roce_reth (roce_reth)
  );

  filter_policy u_policy (
    .is_ipv4       (is_ipv4),
    .is_ipv6       (is_ipv6),
    .is_arp        (is_arp),
    .is_icmp4      (is_icmp4),
    .is_icmp6      (is_icmp6),
    .is_udp4       (is_udp4),
    .is_udp6       (is_udp6),
    .is_tcp4       (is_tcp4),
    .is_roce4      (is_roce4),
    .roce_aeth     (roce_aeth),
    .roce_reth     (roce_reth),
    .filter_config (filter_config),
    .first_beat    (!in_pkt),
    .pkt_dropped   (pkt_dropped),
    .hdr_remaining (hdr_remaining),
    .drop_beat     (drop_beat),
    .cut_beat      (cut_beat),
    .cut_keep      (cut_keep),
    .spill         (spill)
  );

  // Filtered view, data always follows the input
  assign filt_tvalid = accept && !drop_beat;
  assign filt_tdata  = in_tdata;
  // Cut beat closes the filtered packet early
  assign filt_tkeep  = cut_beat ? cut_keep : in_tkeep;
  assign filt_tlast  = cut_beat || in_tlast;

  // Packet position, drop and spill state
  always_ff @(posedge nclk) begin
    if (!nresetn_r) begin
      in_pkt        <= 1'b0;
      pkt_dropped   <= 1'b0;
      hdr_remaining <= 1'b0;
    end else if (accept) begin
      if (in_tlast) begin
        in_pkt        <= 1'b0;
        pkt_dropped   <= 1'b0;
        hdr_remaining <= 1'b0;
      end else begin
        in_pkt        <= 1'b1;
        // Everything after a drop or a cut is discarded
        pkt_dropped   <= pkt_dropped || drop_beat || cut_beat;
        hdr_remaining <= spill;
      end
    end
  end

  // Header cut always leaves some bytes
  cut_keep_nonzero: assert property (
    @(posedge nclk) disable iff (!nresetn_r)
    (accept && cut_beat) |-> (filt_tkeep != '0));

endmodule

`default_nettype wire

/* rtl/filter_policy.sv */
/*
  Pure decision logic; outputs are only used on accepted beats.
  Trim priority is UDP4, UDP6, TCP4, then RoCE4. A RoCE RETH header
  spills 6 bytes into the second beat, which is cut there.
*/
`timescale 1ns/1ps
`default_nettype none

module filter_policy
  import pkt_filter_pkg::*;
(
  input  logic              is_ipv4,
  input  logic              is_ipv6,
  input  logic              is_arp,
  input  logic              is_icmp4,
  input  logic              is_icmp6,
  input  logic              is_udp4,
  input  logic              is_udp6,
  input  logic              is_tcp4,
  input  logic              is_roce4,
  input  logic              roce_aeth,
  input  logic              roce_reth,
  input  logic [CFG_W-1:0]  filter_config,
  input  logic              first_beat,
  input  logic              pkt_dropped,
  input  logic              hdr_remaining,
  output logic              drop_beat,
  output logic              cut_beat,
  output logic [KEEP_W-1:0] cut_keep,
  output logic              spill
);

  // Keep masks for each header length
  localparam logic [KEEP_W-1:0] KEEP_UDP4      = keep_low(HDR_UDP4);
  localparam logic [KEEP_W-1:0] KEEP_UDP6      = keep_low(HDR_UDP6);
  localparam logic [KEEP_W-1:0] KEEP_TCP4      = keep_low(HDR_TCP4);
  localparam logic [KEEP_W-1:0] KEEP_ROCE      = keep_low(HDR_ROCE);
  localparam logic [KEEP_W-1:0] KEEP_ROCE_AETH = keep_low(HDR_ROCE_AETH);
  // Part of the RETH header left over for the second beat
  localparam logic [KEEP_W-1:0] KEEP_RETH_TAIL = keep_low(HDR_ROCE_RETH - BEAT_BYTES);

  logic drop_match;

  // Any enabled drop class hit on the first beat
  assign drop_match = first_beat && (
      (is_ipv4  && filter_config[CFG_DROP_IPV4])  ||
      (is_ipv6  && filter_config[CFG_DROP_IPV6])  ||
      (is_arp   && filter_config[CFG_DROP_ARP])   ||
      (is_icmp4 && filter_config[CFG_DROP_ICMP4]) ||
      (is_icmp6 && filter_config[CFG_DROP_ICMP6]) ||
      (is_udp4  && filter_config[CFG_DROP_UDP4])  ||
      (is_udp6  && filter_config[CFG_DROP_UDP6])  ||
      (is_tcp4  && filter_config[CFG_DROP_TCP4])  ||
      (is_roce4 && filter_config[CFG_DROP_ROCE4]));

  always_comb begin
    drop_beat = 1'b0;
    cut_beat  = 1'b0;
    cut_keep  = '0;
    spill     = 1'b0;
    if (drop_match || (!first_beat && pkt_dropped)) begin
      // Whole packet, or the tail after a cut
      drop_beat = 1'b1;
    end else if (first_beat) begin
      if (is_udp4 && filter_config[CFG_TRIM_UDP4]) begin
        cut_beat = 1'b1;
        cut_keep = KEEP_UDP4;
      end else if (is_udp6 && filter_config[CFG_TRIM_UDP6]) begin
        cut_beat = 1'b1;
        cut_keep = KEEP_UDP6;
      end else if (is_tcp4 && filter_config[CFG_TRIM_TCP4]) begin
        cut_beat = 1'b1;
        cut_keep = KEEP_TCP4;
      end else if (is_roce4 && filter_config[CFG_TRIM_ROCE4]) begin
        if (roce_aeth) begin
          cut_beat = 1'b1;
          cut_keep = KEEP_ROCE_AETH;
        end else if (roce_reth) begin
          // Header runs past this beat, pass it whole
          spill = 1'b1;
        end else begin
          // BTH only
          cut_beat = 1'b1;
          cut_keep = KEEP_ROCE;
        end
      end
    end else if (hdr_remaining) begin
      // Second beat of a RETH header
      cut_beat = 1'b1;
      cut_keep = KEEP_RETH_TAIL;
    end
  end

endmodule

`default_nettype wire

/* rtl/pkt_filter_pkg.sv */
/*
  Beats are fixed at 64 bytes and the IPv4 header is always taken as 20 bytes
  without options, so every header offset below is a constant.
  Multi-byte header fields are compared in network byte order.
*/
`default_nettype none

package pkt_filter_pkg;

  // Stream geometry
  localparam int unsigned BEAT_BYTES = 64;
  localparam int unsigned DATA_W     = BEAT_BYTES * 8;
  localparam int unsigned KEEP_W     = BEAT_BYTES;
  localparam int unsigned CFG_W      = 64;

  // Byte offsets inside the first beat
  localparam int unsigned OFF_ETHERTYPE  = 12;
  localparam int unsigned OFF_IPV4_PROTO = 23;
  localparam int unsigned OFF_IPV6_NEXT  = 20;
  localparam int unsigned OFF_UDP4_DPORT = 36;
  localparam int unsigned OFF_BTH_OPCODE = 42;

  // EtherType codes
  localparam logic [15:0] ETH_IPV4 = 16'h0800;
  localparam logic [15:0] ETH_IPV6 = 16'h86DD;
  localparam logic [15:0] ETH_ARP  = 16'h0806;

  // IP protocol and IPv6 next header codes
  localparam logic [7:0] IP_ICMP  = 8'd1;
  localparam logic [7:0] IP_ICMP6 = 8'd58;
  localparam logic [7:0] IP_UDP   = 8'd17;
  localparam logic [7:0] IP_TCP   = 8'd6;

  // RoCEv2 well known UDP port
  localparam logic [15:0] ROCE_PORT = 16'd4791;

  // BTH opcodes followed by an AETH
  // RC read response only/first/last and RC ack
  localparam logic [3:0][7:0] OP_AETH = {8'h11, 8'h10, 8'h0F, 8'h0D};
  // BTH opcodes followed by a RETH
  // RC write first/only, write only with immediate, read request
  localparam logic [3:0][7:0] OP_RETH = {8'h0C, 8'h0B, 8'h0A, 8'h06};

  // Configuration bits, drop whole packet
  localparam int unsigned CFG_DROP_IPV4  = 8;
  localparam int unsigned CFG_DROP_IPV6  = 9;
  localparam int unsigned CFG_DROP_ARP   = 16;
  localparam int unsigned CFG_DROP_ICMP4 = 18;
  localparam int unsigned CFG_DROP_ICMP6 = 20;
  localparam int unsigned CFG_DROP_UDP4  = 22;
  localparam int unsigned CFG_DROP_UDP6  = 24;
  localparam int unsigned CFG_DROP_TCP4  = 26;
  localparam int unsigned CFG_DROP_ROCE4 = 30;

  // Configuration bits, keep headers only
  localparam int unsigned CFG_TRIM_UDP4  = 23;
  localparam int unsigned CFG_TRIM_UDP6  = 25;
  localparam int unsigned CFG_TRIM_TCP4  = 27;
  localparam int unsigned CFG_TRIM_ROCE4 = 31;

  // Header lengths in bytes, Ethernet header included
  localparam int unsigned HDR_UDP4      = 42;
  localparam int unsigned HDR_UDP6      = 62;
  // TCP options are not counted
  localparam int unsigned HDR_TCP4      = 54;
  localparam int unsigned HDR_ROCE      = 54;
  localparam int unsigned HDR_ROCE_AETH = 58;
  // Longer than one beat
  localparam int unsigned HDR_ROCE_RETH = 70;

  // Keep mask with the low n bytes set
  function automatic logic [KEEP_W-1:0] keep_low(input int unsigned n);
    logic [KEEP_W-1:0] mask;
    mask = '0;
    for (int i = 0; i < KEEP_W; i++) begin
      mask[i] = (i < n);
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

/* rtl/pkt_filter_top.sv */
/*
  Bidirectional filter for a sniffer tap. A new configuration word
  takes effect on the cycle after the cfg_valid strobe, and after reset
  the configuration is zero so every packet passes whole.
*/
`timescale 1ns/1ps
`default_nettype none

module pkt_filter_top
  import pkt_filter_pkg::*;
(
  input  logic              nclk,
  input  logic              nresetn_r,
  // Configuration load
  input  logic              cfg_valid,
  input  logic [CFG_W-1:0]  cfg_data,
  // RX input
  input  logic              rx_in_tvalid,
  output logic              rx_in_tready,
  input  logic [DATA_W-1:0] rx_in_tdata,
  input  logic [KEEP_W-1:0] rx_in_tkeep,
  input  logic              rx_in_tlast,
  // RX pass-through
  output logic              rx_pass_tvalid,
  input  logic              rx_pass_tready,
  output logic [DATA_W-1:0] rx_pass_tdata,
  output logic [KEEP_W-1:0] rx_pass_tkeep,
  output logic              rx_pass_tlast,
  // RX filtered
  output logic              rx_filt_tvalid,
  input  logic              rx_filt_tready,
  output logic [DATA_W-1:0] rx_filt_tdata,
  output logic [KEEP_W-1:0] rx_filt_tkeep,
  output logic              rx_filt_tlast,
  // TX input
  input  logic              tx_in_tvalid,
  output logic              tx_in_tready,
  input  logic [DATA_W-1:0] tx_in_tdata,
  input  logic [KEEP_W-1:0] tx_in_tkeep,
  input  logic              tx_in_tlast,
  // TX pass-through
  output logic              tx_pass_tvalid,
  input  logic              tx_pass_tready,
  output logic [DATA_W-1:0] tx_pass_tdata,
  output logic [KEEP_W-1:0] tx_pass_tkeep,
  output logic              tx_pass_tlast,
  // TX filtered
  output logic              tx_filt_tvalid,
  input  logic              tx_filt_tready,
  output logic [DATA_W-1:0] tx_filt_tdata,
  output logic [KEEP_W-1:0] tx_filt_tkeep,
  output logic              tx_filt_tlast
);

  logic [CFG_W-1:0] filter_config;

  // Shared configuration word
  always_ff @(posedge nclk) begin
    if (!nresetn_r) begin
      filter_config <= '0;
    end else if (cfg_valid) begin
      filter_config <= cfg_data;
    end
  end

  filter_channel rx_channel (
    .nclk          (nclk),
    .nresetn_r     (nresetn_r),
    .filter_config (filter_config),
    .in_tvalid     (rx_in_tvalid),
    .in_tready     (rx_in_tready),
    .in_tdata      (rx_in_tdata),
    .in_tkeep      (rx_in_tkeep),
    .in_tlast      (rx_in_tlast),
    .pass_tvalid   (rx_pass_tvalid),
    .pass_tready   (rx_pass_tready),
    .pass_tdata    (rx_pass_tdata),
    .pass_tkeep    (rx_pass_tkeep),
    .pass_tlast    (rx_pass_tlast),
    .filt_tvalid   (rx_filt_tvalid),
    .filt_tready   (rx_filt_tready),
    .filt_tdata    (rx_filt_tdata),
    .filt_tkeep    (rx_filt_tkeep),
    .filt_tlast    (rx_filt_tlast)
  );

  filter_channel tx_channel (
    .nclk          (nclk),
    .nresetn_r     (nresetn_r),
    .filter_config (filter_config),
    .in_tvalid     (tx_in_tvalid),
    .in_tready     (tx_in_tready),
    .in_tdata      (tx_in_tdata),
    .in_tkeep      (tx_in_tkeep),
    .in_tlast      (tx_in_tlast),
    .pass_tvalid   (tx_pass_tvalid),
    .pass_tready   (tx_pass_tready),
    .pass_tdata    (tx_pass_tdata),
    .pass_tkeep    (tx_pass_tkeep),
    .pass_tlast    (tx_pass_tlast),
    .filt_tvalid   (tx_filt_tvalid),
    .filt_tready   (tx_filt_tready),
    .filt_tdata    (tx_filt_tdata),
    .filt_tkeep    (tx_filt_tkeep),
    .filt_tlast    (tx_filt_tlast)
  );

  // Loaded word must be fully defined
  cfg_known: assert property (
    @(posedge nclk) disable iff (!nresetn_r)
    cfg_valid |-> !$isunknown(cfg_data));

endmodule

`default_nettype wire

/* rtl/proto_classifier.sv */
/*
  Flags are only meaningful on the first beat of a packet.
  IPv4 is assumed to carry a 20 byte header, so IPv4 packets with
  options may be misclassified.
*/
`timescale 1ns/1ps
`default_nettype none

module proto_classifier
  import pkt_filter_pkg::*;
(
  input  logic [DATA_W-1:0] beat,
  output logic              is_ipv4,
  output logic              is_ipv6,
  output logic              is_arp,
  output logic              is_icmp4,
  output logic              is_icmp6,
  output logic              is_udp4,
  output logic              is_udp6,
  output logic              is_tcp4,
  output logic              is_roce4,
  output logic              roce_aeth,
  output logic              roce_reth
);

  // Byte idx of the beat, byte 0 is the first on the wire
  function automatic logic [7:0] beat_byte(input logic [DATA_W-1:0] w,
                                           input int unsigned idx);
    return w[idx*8 +: 8];
  endfunction

  logic [15:0] ethertype;
  logic [7:0]  ipv4_proto;
  logic [7:0]  ipv6_next;
  logic [15:0] udp_dport;
  logic [7:0]  bth_opcode;
  logic        op_aeth;
  logic        op_reth;

  // Header fields at fixed offsets
  // First byte is the most significant one
  assign ethertype  = {beat_byte(beat, OFF_ETHERTYPE), beat_byte(beat, OFF_ETHERTYPE + 1)};
  assign ipv4_proto = beat_byte(beat, OFF_IPV4_PROTO);
  assign ipv6_next  = beat_byte(beat, OFF_IPV6_NEXT);
  assign udp_dport  = {beat_byte(beat, OFF_UDP4_DPORT), beat_byte(beat, OFF_UDP4_DPORT + 1)};
  assign bth_opcode = beat_byte(beat, OFF_BTH_OPCODE);

  // Opcode group lookup
  always_comb begin
    op_aeth = 1'b0;
    op_reth = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (bth_opcode == OP_AETH[i]) begin
        op_aeth = 1'b1;
      end
      if (bth_opcode == OP_RETH[i]) begin
        op_reth = 1'b1;
      end
    end
  end

  // Layer 2 and 3
  assign is_ipv4 = (ethertype == ETH_IPV4);
  assign is_ipv6 = (ethertype == ETH_IPV6);
  assign is_arp  = (ethertype == ETH_ARP);

  // Layer 4 over IPv4
  assign is_icmp4 = is_ipv4 && (ipv4_proto == IP_ICMP);
  assign is_udp4  = is_ipv4 && (ipv4_proto == IP_UDP);
  assign is_tcp4  = is_ipv4 && (ipv4_proto == IP_TCP);

  // Layer 4 over IPv6, no extension headers walked
  assign is_icmp6 = is_ipv6 && (ipv6_next == IP_ICMP6);
  assign is_udp6  = is_ipv6 && (ipv6_next == IP_UDP);

  // RoCEv2 by UDP destination port
  assign is_roce4 = is_udp4 && (udp_dport == ROCE_PORT);

  // Extra transport header after the BTH
  assign roce_aeth = is_roce4 && op_aeth;
  assign roce_reth = is_roce4 && op_reth;

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
/*
  Watches one direction of the tap. Per-packet counts are compared and
  cleared by check_packet, which the testbench top calls between packets.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import pkt_filter_pkg::*;
(
  input  logic              nclk,
  input  logic              in_tvalid,
  input  logic              in_tready,
  input  logic [DATA_W-1:0] in_tdata,
  input  logic [KEEP_W-1:0] in_tkeep,
  input  logic              in_tlast,
  input  logic              pass_tvalid,
  input  logic              pass_tready,
  input  logic [DATA_W-1:0] pass_tdata,
  input  logic [KEEP_W-1:0] pass_tkeep,
  input  logic              pass_tlast,
  input  logic              filt_tvalid,
  input  logic              filt_tready,
  input  logic [DATA_W-1:0] filt_tdata,
  input  logic [KEEP_W-1:0] filt_tkeep,
  input  logic              filt_tlast,
  output int                errors
);

  string             test_name = "idle";
  int                in_beats = 0;
  int                pass_beats = 0;
  int                filt_beats = 0;
  int                filt_lasts = 0;
  logic [KEEP_W-1:0] last_keep = '0;

  initial errors = 0;

  // Mask with the low n bytes valid
  function automatic logic [KEEP_W-1:0] low_bytes(input int n);
    logic [KEEP_W:0] wide;
    wide = ({{KEEP_W{1'b0}}, 1'b1} << n) - 1'b1;
    return wide[KEEP_W-1:0];
  endfunction

  task automatic value_error(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic set_test(input string name);
    test_name = name;
  endtask

  // Sampled at the edge, where the handshake is stable
  always @(posedge nclk) begin
    if (in_tvalid && in_tready) begin
      in_beats++;
    end
    if (pass_tvalid && pass_tready) begin
      pass_beats++;
      // Pass-through is a straight copy
      if (pass_tdata !== in_tdata) value_error("pass tdata", in_tdata, pass_tdata);
      if (pass_tkeep !== in_tkeep) value_error("pass tkeep", in_tkeep, pass_tkeep);
      if (pass_tlast !== in_tlast) value_error("pass tlast", in_tlast, pass_tlast);
    end
    if (filt_tvalid && filt_tready) begin
      filt_beats++;
      if (filt_tdata !== in_tdata) value_error("filt tdata", in_tdata, filt_tdata);
      if (filt_tlast) begin
        filt_lasts++;
        last_keep = filt_tkeep;
      end else if (filt_tkeep !== in_tkeep) begin
        // Only the closing beat may be trimmed
        value_error("filt tkeep", in_tkeep, filt_tkeep);
      end
    end
  end

  // Compare one packet, then start counting afresh
  task automatic check_packet(input int exp_beats, input int exp_filt, input int keep_bytes);
    int exp_lasts;
    exp_lasts = (exp_filt > 0) ? 1 : 0;
    if (in_beats != exp_beats) value_error("input beats", exp_beats, in_beats);
    if (pass_beats != exp_beats) value_error("pass-through beats", exp_beats, pass_beats);
    if (filt_beats != exp_filt) value_error("filtered beats", exp_filt, filt_beats);
    if (filt_lasts != exp_lasts) value_error("filtered last flags", exp_lasts, filt_lasts);
    if (exp_filt > 0 && last_keep !== low_bytes(keep_bytes)) begin
      value_error("last keep", low_bytes(keep_bytes), last_keep);
    end
    in_beats   = 0;
    pass_beats = 0;
    filt_beats = 0;
    filt_lasts = 0;
    last_keep  = '0;
  endtask

endmodule

`default_nettype wire

/* tb/tb_top.sv */
/*
  One packet per table row, each after its own configuration load.
  Index 0 of the stream vectors is RX, index 1 is TX.
  Last input beats carry 60 valid bytes, all others 64.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import pkt_filter_pkg::*;
();

  localparam int MAX_ROWS = 40;
  // Packet templates
  localparam int PR_IPV4  = 0;
  localparam int PR_IPV6  = 1;
  localparam int PR_ARP   = 2;
  localparam int PR_ICMP4 = 3;
  localparam int PR_ICMP6 = 4;
  localparam int PR_UDP4  = 5;
  localparam int PR_UDP6  = 6;
  localparam int PR_TCP4  = 7;
  localparam int PR_ROCE4 = 8;
  localparam logic [KEEP_W-1:0] LAST_KEEP = 64'h0FFF_FFFF_FFFF_FFFF;

  logic                   nclk;
  logic                   nresetn_r;
  logic                   cfg_valid;
  logic [CFG_W-1:0]       cfg_data;
  logic [1:0]             in_tvalid;
  wire  [1:0]             in_tready;
  logic [1:0][DATA_W-1:0] in_tdata;
  logic [1:0][KEEP_W-1:0] in_tkeep;
  logic [1:0]             in_tlast;
  wire  [1:0]             pass_tvalid;
  logic [1:0]             pass_tready;
  wire  [1:0][DATA_W-1:0] pass_tdata;
  wire  [1:0][KEEP_W-1:0] pass_tkeep;
  wire  [1:0]             pass_tlast;
  wire  [1:0]             filt_tvalid;
  logic [1:0]             filt_tready;
  wire  [1:0][DATA_W-1:0] filt_tdata;
  wire  [1:0][KEEP_W-1:0] filt_tkeep;
  wire  [1:0]             filt_tlast;
  int                     rx_errors;
  int                     tx_errors;
  logic                   stall_en;
  logic                   table_done;
  logic [31:0]            rnd;
  integer                 seed = 32'h3e05_e966;

  // Stimulus table
  int               n_rows;
  string            row_name  [MAX_ROWS];
  int               row_dir   [MAX_ROWS];
  logic [CFG_W-1:0] row_cfg   [MAX_ROWS];
  int               row_proto [MAX_ROWS];
  logic [7:0]       row_op    [MAX_ROWS];
  int               row_beats [MAX_ROWS];
  int               row_filt  [MAX_ROWS];
  int               row_keep  [MAX_ROWS];
  logic             row_stall [MAX_ROWS];

  always #10 nclk = ~nclk;

  pkt_filter_top uut (
    .nclk           (nclk),
    .nresetn_r      (nresetn_r),
    .cfg_valid      (cfg_valid),
    .cfg_data       (cfg_data),
    .rx_in_tvalid   (in_tvalid[0]),
    .rx_in_tready   (in_tready[0]),
    .rx_in_tdata    (in_tdata[0]),
    .rx_in_tkeep    (in_tkeep[0]),
    .rx_in_tlast    (in_tlast[0]),
    .rx_pass_tvalid (pass_tvalid[0]),
    .rx_pass_tready (pass_tready[0]),
    .rx_pass_tdata  (pass_tdata[0]),
    .rx_pass_tkeep  (pass_tkeep[0]),
    .rx_pass_tlast  (pass_tlast[0]),
    .rx_filt_tvalid (filt_tvalid[0]),
    .rx_filt_tready (filt_tready[0]),
    .rx_filt_tdata  (filt_tdata[0]),
    .rx_filt_tkeep  (filt_tkeep[0]),
    .rx_filt_tlast  (filt_tlast[0]),
    .tx_in_tvalid   (in_tvalid[1]),
    .tx_in_tready   (in_tready[1]),
    .tx_in_tdata    (in_tdata[1]),
    .tx_in_tkeep    (in_tkeep[1]),
    .tx_in_tlast    (in_tlast[1]),
    .tx_pass_tvalid (pass_tvalid[1]),
    .tx_pass_tready (pass_tready[1]),
    .tx_pass_tdata  (pass_tdata[1]),
    .tx_pass_tkeep  (pass_tkeep[1]),
    .tx_pass_tlast  (pass_tlast[1]),
    .tx_filt_tvalid (filt_tvalid[1]),
    .tx_filt_tready (filt_tready[1]),
    .tx_filt_tdata  (filt_tdata[1]),
    .tx_filt_tkeep  (filt_tkeep[1]),
    .tx_filt_tlast  (filt_tlast[1])
  );

  tb_checker rx_chk (
    .nclk        (nclk),
    .in_tvalid   (in_tvalid[0]),
    .in_tready   (in_tready[0]),
    .in_tdata    (in_tdata[0]),
    .in_tkeep    (in_tkeep[0]),
    .in_tlast    (in_tlast[0]),
    .pass_tvalid (pass_tvalid[0]),
    .pass_tready (pass_tready[0]),
    .pass_tdata  (pass_tdata[0]),
    .pass_tkeep  (pass_tkeep[0]),
    .pass_tlast  (pass_tlast[0]),
    .filt_tvalid (filt_tvalid[0]),
    .filt_tready (filt_tready[0]),
    .filt_tdata  (filt_tdata[0]),
    .filt_tkeep  (filt_tkeep[0]),
    .filt_tlast  (filt_tlast[0]),
    .errors      (rx_errors)
  );

  tb_checker tx_chk (
    .nclk        (nclk),
    .in_tvalid   (in_tvalid[1]),
    .in_tready   (in_tready[1]),
    .in_tdata    (in_tdata[1]),
    .in_tkeep    (in_tkeep[1]),
    .in_tlast    (in_tlast[1]),
    .pass_tvalid (pass_tvalid[1]),
    .pass_tready (pass_tready[1]),
    .pass_tdata  (pass_tdata[1]),
    .pass_tkeep  (pass_tkeep[1]),
    .pass_tlast  (pass_tlast[1]),
    .filt_tvalid (filt_tvalid[1]),
    .filt_tready (filt_tready[1]),
    .filt_tdata  (filt_tdata[1]),
    .filt_tkeep  (filt_tkeep[1]),
    .filt_tlast  (filt_tlast[1]),
    .errors      (tx_errors)
  );

  // Sink readies, randomly low only on stall rows
  always @(posedge nclk) begin
    if (stall_en) begin
      rnd = $random(seed);
      pass_tready[0] <= |rnd[1:0];
      pass_tready[1] <= |rnd[3:2];
      filt_tready[0] <= |rnd[5:4];
      filt_tready[1] <= |rnd[7:6];
    end else begin
      pass_tready <= 2'b11;
      filt_tready <= 2'b11;
    end
  end

  // Beat contents; header fields only in the first beat
  function automatic logic [DATA_W-1:0] make_beat(input int proto, input logic [7:0] op,
                                                  input int beat_idx, input int row);
    logic [DATA_W-1:0] w;
    int                fill;
    for (int i = 0; i < BEAT_BYTES; i++) begin
      fill = i * 7 + beat_idx * 29 + row * 13;
      w[i*8 +: 8] = fill[7:0];
    end
    if (beat_idx == 0) begin
      // EtherType, network order
      case (proto)
        PR_IPV6, PR_ICMP6, PR_UDP6: {w[12*8 +: 8], w[13*8 +: 8]} = 16'h86DD;
        PR_ARP:                     {w[12*8 +: 8], w[13*8 +: 8]} = 16'h0806;
        default:                    {w[12*8 +: 8], w[13*8 +: 8]} = 16'h0800;
      endcase
      // IPv4 protocol at byte 23, IPv6 next header at byte 20
      case (proto)
        PR_IPV4:           w[23*8 +: 8] = 8'h32;
        PR_ICMP4:          w[23*8 +: 8] = 8'h01;
        PR_UDP4, PR_ROCE4: w[23*8 +: 8] = 8'h11;
        PR_TCP4:           w[23*8 +: 8] = 8'h06;
        PR_IPV6:           w[20*8 +: 8] = 8'h3B;
        PR_ICMP6:          w[20*8 +: 8] = 8'h3A;
        PR_UDP6:           w[20*8 +: 8] = 8'h11;
        default:           ;
      endcase
      // UDP destination port, DNS or RoCEv2
      if (proto == PR_UDP4) begin
        {w[36*8 +: 8], w[37*8 +: 8]} = 16'h0035;
      end
      if (proto == PR_ROCE4) begin
        {w[36*8 +: 8], w[37*8 +: 8]} = 16'h12B7;
        w[42*8 +: 8] = op;
      end
    end
    return w;
  endfunction

  task automatic add_row(input string name, input int dir, input logic [CFG_W-1:0] cfg,
                         input int proto, input logic [7:0] op, input int beats,
                         input int filt, input int keep, input logic stall);
    row_name[n_rows]  = name;
    row_dir[n_rows]   = dir;
    row_cfg[n_rows]   = cfg;
    row_proto[n_rows] = proto;
    row_op[n_rows]    = op;
    row_beats[n_rows] = beats;
    row_filt[n_rows]  = filt;
    row_keep[n_rows]  = keep;
    row_stall[n_rows] = stall;
    n_rows++;
  endtask

  // name, dir, config, template, opcode, beats, filtered beats, last keep bytes, stall
  task automatic build_table();
    n_rows = 0;
    // Zero configuration passes everything whole
    add_row("zero_ipv4",  0, 64'h0, PR_IPV4,  8'h00, 3, 3, 60, 1'b0);
    add_row("zero_ipv6",  1, 64'h0, PR_IPV6,  8'h00, 2, 2, 60, 1'b0);
    add_row("zero_arp",   0, 64'h0, PR_ARP,   8'h00, 1, 1, 60, 1'b0);
    add_row("zero_icmp4", 1, 64'h0, PR_ICMP4, 8'h00, 2, 2, 60, 1'b0);
    add_row("zero_icmp6", 0, 64'h0, PR_ICMP6, 8'h00, 2, 2, 60, 1'b0);
    add_row("zero_udp4",  1, 64'h0, PR_UDP4,  8'h00, 3, 3, 60, 1'b0);
    add_row("zero_udp6",  0, 64'h0, PR_UDP6,  8'h00, 2, 2, 60, 1'b0);
    add_row("zero_tcp4",  1, 64'h0, PR_TCP4,  8'h00, 4, 4, 60, 1'b0);
    add_row("zero_roce4", 0, 64'h0, PR_ROCE4, 8'h04, 3, 3, 60, 1'b0);
    // One drop bit each
    add_row("drop_ipv4",  1, 64'h0000_0100, PR_IPV4,  8'h00, 2, 0, 0, 1'b0);
    add_row("drop_ipv6",  0, 64'h0000_0200, PR_UDP6,  8'h00, 2, 0, 0, 1'b0);
    add_row("drop_arp",   1, 64'h0001_0000, PR_ARP,   8'h00, 1, 0, 0, 1'b0);
    add_row("drop_icmp4", 0, 64'h0004_0000, PR_ICMP4, 8'h00, 2, 0, 0, 1'b0);
    add_row("drop_icmp6", 1, 64'h0010_0000, PR_ICMP6, 8'h00, 2, 0, 0, 1'b0);
    add_row("drop_udp4",  0, 64'h0040_0000, PR_UDP4,  8'h00, 3, 0, 0, 1'b0);
    add_row("drop_udp6",  1, 64'h0100_0000, PR_UDP6,  8'h00, 2, 0, 0, 1'b0);
    add_row("drop_tcp4",  0, 64'h0400_0000, PR_TCP4,  8'h00, 3, 0, 0, 1'b0);
    add_row("drop_roce4", 1, 64'h4000_0000, PR_ROCE4, 8'h0D, 3, 0, 0, 1'b0);
    // Header trims
    add_row("trim_udp4",     1, 64'h0080_0000, PR_UDP4, 8'h00, 3, 1, 42, 1'b0);
    add_row("trim_udp6",     0, 64'h0200_0000, PR_UDP6, 8'h00, 3, 1, 62, 1'b0);
    add_row("trim_tcp4",     1, 64'h0800_0000, PR_TCP4, 8'h00, 2, 1, 54, 1'b0);
    add_row("trim_udp4_one", 0, 64'h0080_0000, PR_UDP4, 8'h00, 1, 1, 42, 1'b0);
    // RoCE opcode groups, then UDP4 trim taking priority
    add_row("roce_aeth",  0, 64'h8000_0000, PR_ROCE4, 8'h11, 3, 1, 58, 1'b0);
    add_row("roce_plain", 1, 64'h8000_0000, PR_ROCE4, 8'h04, 2, 1, 54, 1'b0);
    add_row("roce_reth",  0, 64'h8000_0000, PR_ROCE4, 8'h06, 4, 2, 6, 1'b0);
    add_row("trim_prio",  1, 64'h8080_0000, PR_ROCE4, 8'h11, 2, 1, 42, 1'b0);
    // Random back-pressure on all sinks
    add_row("stall_tcp4", 0, 64'h0,         PR_TCP4,  8'h00, 5, 5, 60, 1'b1);
    add_row("stall_reth", 1, 64'h8000_0000, PR_ROCE4, 8'h0A, 4, 2, 6, 1'b1);
    add_row("stall_drop", 0, 64'h0100_0000, PR_UDP6,  8'h00, 3, 0, 0, 1'b1);
    // Configuration changes between packets
    add_row("chg_tx_pass", 1, 64'h0400_0000, PR_UDP4, 8'h00, 2, 2, 60, 1'b0);
    add_row("chg_tx_drop", 1, 64'h0400_0000, PR_TCP4, 8'h00, 2, 0, 0, 1'b0);
    add_row("chg_rx_trim", 0, 64'h0800_0000, PR_TCP4, 8'h00, 2, 1, 54, 1'b0);
    add_row("chg_rx_back", 0, 64'h0,         PR_TCP4, 8'h00, 2, 2, 60, 1'b0);
  endtask

  // Returns at the edge that accepts the current beat
  task automatic wait_accept(input int d);
    @(posedge nclk);
    while (!in_tready[d]) begin
      @(posedge nclk);
    end
  endtask

  task automatic run_row(input int r);
    int d;
    int last;
    d    = row_dir[r];
    last = row_beats[r] - 1;
    rx_chk.set_test(row_name[r]);
    tx_chk.set_test(row_name[r]);
    // Config strobe, new word holds before the first beat is taken
    @(posedge nclk);
    stall_en  <= row_stall[r];
    cfg_valid <= 1'b1;
    cfg_data  <= row_cfg[r];
    @(posedge nclk);
    cfg_valid <= 1'b0;
    for (int b = 0; b <= last; b++) begin
      in_tvalid[d] <= 1'b1;
      in_tdata[d]  <= make_beat(row_proto[r], row_op[r], b, r);
      in_tkeep[d]  <= (b == last) ? LAST_KEEP : {KEEP_W{1'b1}};
      in_tlast[d]  <= (b == last);
      wait_accept(d);
    end
    in_tvalid[d] <= 1'b0;
    // Idle direction must stay silent
    @(negedge nclk);
    if (d == 0) begin
      rx_chk.check_packet(row_beats[r], row_filt[r], row_keep[r]);
      tx_chk.check_packet(0, 0, 0);
    end else begin
      tx_chk.check_packet(row_beats[r], row_filt[r], row_keep[r]);
      rx_chk.check_packet(0, 0, 0);
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d rows, rx errors %0d, tx errors %0d", n_rows, rx_errors, tx_errors);
  endtask

  initial begin
    nclk        = 1'b0;
    nresetn_r   = 1'b0;
    cfg_valid   = 1'b0;
    cfg_data    = '0;
    in_tvalid   = '0;
    in_tdata    = '0;
    in_tkeep    = '0;
    in_tlast    = '0;
    pass_tready = 2'b11;
    filt_tready = 2'b11;
    stall_en    = 1'b0;
    table_done  = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (2) @(posedge nclk);
    nresetn_r <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    repeat (2) @(posedge nclk);
    print_summary();
    if (rx_errors == 0 && tx_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Four cycles per beat plus config and check cycles per row
  initial begin : watchdog
    int limit;
    wait (table_done === 1'b1);
    limit = 100;
    for (int r = 0; r < n_rows; r++) begin
      limit += row_beats[r] * 4 + 4;
    end
    repeat (limit) @(posedge nclk);
    $display("Watchdog timeout: tests did not finish within %0d cycles", limit);
    print_summary();
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
